/* run_sim.sh */
#!/bin/sh
# builds the viterbi decoder testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
  --top-module tb_viterbi_decoder -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

/* sources.f */
+incdir+src
src/viterbi_pkg.sv
src/add_compare_select.sv
src/survivor_memory.sv
src/viterbi_control.sv
src/traceback.sv
src/viterbi_decoder.sv
test/tb_viterbi_decoder.sv

/* src/add_compare_select.sv */
`include "viterbi_macros.svh"
`timescale 1ns/10ps

module add_compare_select
  import viterbi_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      acs_en,
  input  logic      frame_start,
  input  code_sym_t sym,
  output state_t    prv_st [`STATE_NUM],
  output state_t    sel_node,
  output metric_t   best_metric
);

  localparam metric_t METRIC_MAX = '1;

  metric_t pm      [`STATE_NUM];
  metric_t pm_base [`STATE_NUM];
  metric_t pm_next [`STATE_NUM];
  logic    next_at_max;

  // hamming distance between rx and the branch leaving from on bit_in
  function automatic logic [1:0] branch_dist(code_sym_t rx, state_t from, logic bit_in);
    code_sym_t expect_sym;
    code_sym_t diff;
    // g0 = u ^ u1 ^ u2, g1 = u ^ u2
    expect_sym[1] = bit_in ^ from[1] ^ from[0];
    expect_sym[0] = bit_in ^ from[0];
    diff = rx ^ expect_sym;
    return {1'b0, diff[1]} + {1'b0, diff[0]};
  endfunction

  // add with clamp at the top code
  function automatic metric_t add_sat(metric_t m, logic [1:0] bm);
    logic [`METRIC_WIDTH:0] sum;
    sum = {1'b0, m} + {{(`METRIC_WIDTH-1){1'b0}}, bm};
    if (sum[`METRIC_WIDTH]) begin
      return METRIC_MAX;
    end
    return sum[`METRIC_WIDTH-1:0];
  endfunction

  always_comb begin
    state_t  nxt;
    state_t  p_lo;
    state_t  p_hi;
    metric_t m_lo;
    metric_t m_hi;
    // first symbol of a frame starts from state 0 only
    for (int s = 0; s < `STATE_NUM; s++) begin
      if (frame_start) begin
        pm_base[s] = (s == 0) ? '0 : METRIC_MAX;
      end else begin
        pm_base[s] = pm[s];
      end
    end
    next_at_max = 1'b0;
    for (int n = 0; n < `STATE_NUM; n++) begin
      nxt = state_t'(n);
      // predecessors share the old newest bit, now in bit 0
      p_lo = {nxt[0], 1'b0};
      p_hi = {nxt[0], 1'b1};
      m_lo = add_sat(pm_base[p_lo], branch_dist(sym, p_lo, nxt[1]));
      m_hi = add_sat(pm_base[p_hi], branch_dist(sym, p_hi, nxt[1]));
      // tie keeps the lower predecessor
      if (m_hi < m_lo) begin
        pm_next[n] = m_hi;
        prv_st[n]  = p_hi;
      end else begin
        pm_next[n] = m_lo;
        prv_st[n]  = p_lo;
      end
      if (pm_next[n] == METRIC_MAX) begin
        next_at_max = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < `STATE_NUM; s++) begin
        pm[s] <= (s == 0) ? '0 : METRIC_MAX;
      end
    end else if (acs_en) begin
      pm <= pm_next;
    end
  end

  // lowest metric, lower index wins a tie
  always_comb begin
    sel_node    = '0;
    best_metric = pm[0];
    for (int s = 1; s < `STATE_NUM; s++) begin
      if (pm[s] < best_metric) begin
        best_metric = pm[s];
        sel_node    = state_t'(s);
      end
    end
  end

  // every state is reachable after two steps, so only step 0 may hold the clamp
  a_no_metric_max: assert property (@(posedge clk) disable iff (!rst_n)
    acs_en && !frame_start |-> !next_at_max);

endmodule

/* src/survivor_memory.sv */
`include "viterbi_macros.svh"
`timescale 1ns/10ps

module survivor_memory
  import viterbi_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   wr_en,
  input  step_t  wr_step,
  input  state_t wr_row [`STATE_NUM],
  input  step_t  rd_step,
  output state_t rd_row [`STATE_NUM]
);

  localparam step_t LAST_STEP = step_t'(`DATA_FRAME_LENGTH - 1);

  // one row of previous states per trellis step
  state_t mem [`DATA_FRAME_LENGTH][`STATE_NUM];
  // step the next write should land on
  step_t  wr_expect;

  // written in step order as symbols arrive
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_step] <= wr_row;
    end
  end

  // traceback reads in the same cycle
  assign rd_row = mem[rd_step];

  // next frame starts again at step 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_expect <= '0;
    end else if (wr_en) begin
      wr_expect <= (wr_step == LAST_STEP) ? '0 : wr_step + step_t'(1);
    end
  end

  // rows fill in step order, no step skipped or repeated
  a_wr_in_order: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> wr_step == wr_expect);

endmodule

/* src/traceback.sv */
`include "viterbi_macros.svh"
`timescale 1ns/10ps

module traceback
  import viterbi_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    trace_start,
  input  state_t  sel_node,
  input  metric_t best_metric,
  output step_t   rd_step,
  input  state_t  rd_row [`STATE_NUM],
  output logic    frame_valid,
  input  logic    frame_ready,
  output frame_t  frame_data,
  output metric_t frame_metric,
  output logic    trace_done
);

  localparam step_t LAST_STEP = step_t'(`DATA_FRAME_LENGTH - 1);

  logic   walking;
  // state reached at step rd_step
  state_t node;

  // output handshake ends the frame
  assign trace_done = frame_valid && frame_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      walking     <= 1'b0;
      rd_step     <= '0;
      frame_valid <= 1'b0;
    end else begin
      if (trace_start) begin
        walking <= 1'b1;
        rd_step <= LAST_STEP;
      end else if (walking) begin
        // step 0 is the last one walked
        if (rd_step == '0) begin
          walking     <= 1'b0;
          frame_valid <= 1'b1;
        end else begin
          rd_step <= rd_step - step_t'(1);
        end
      end
      if (trace_done) begin
        frame_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (trace_start) begin
      node         <= sel_node;
      frame_metric <= best_metric;
    end else if (walking) begin
      // newest input bit is the decoded bit
      frame_data[rd_step] <= node[1];
      // follow the survivor back one step
      node <= rd_row[node];
    end
  end

  // frame held under back-pressure
  a_frame_hold: assert property (@(posedge clk) disable iff (!rst_n)
    frame_valid && !frame_ready |=> frame_valid && $stable(frame_data)
      && $stable(frame_metric));

endmodule

/* src/viterbi_control.sv */
`include "viterbi_macros.svh"
`timescale 1ns/10ps

module viterbi_control
  import viterbi_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  sym_valid,
  output logic  sym_ready,
  output logic  acs_en,
  output logic  frame_start,
  output step_t step,
  output logic  trace_start,
  input  logic  trace_done
);

  localparam step_t LAST_STEP = step_t'(`DATA_FRAME_LENGTH - 1);

  ctrl_state_t state;

  // input open only while collecting a frame
  assign sym_ready   = (state == accept);
  assign acs_en      = sym_valid && sym_ready;
  assign frame_start = acs_en && (step == '0);
  // metrics of the last step settle in drain
  assign trace_start = (state == drain);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= accept;
      step  <= '0;
    end else begin
      case (state)
        accept: begin
          if (acs_en) begin
            if (step == LAST_STEP) begin
              step  <= '0;
              state <= drain;
            end else begin
              step <= step + step_t'(1);
            end
          end
        end
        drain: begin
          state <= trace;
        end
        trace: begin
          // frame left the decoder
          if (trace_done) begin
            state <= accept;
          end
        end
        default: begin
          state <= accept;
        end
      endcase
    end
  end

  a_done_not_in_accept: assert property (@(posedge clk) disable iff (!rst_n)
    trace_done |-> state != accept);

endmodule

/* src/viterbi_decoder.sv */
`include "viterbi_macros.svh"
`timescale 1ns/10ps

module viterbi_decoder
  import viterbi_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      sym_valid,
  output logic      sym_ready,
  input  code_sym_t sym,
  output logic      frame_valid,
  input  logic      frame_ready,
  output frame_t    frame_data,
  output metric_t   frame_metric
);

  // sequencer strobes
  logic    acs_en;
  logic    frame_start;
  step_t   step;
  logic    trace_start;
  logic    trace_done;
  // decisions into survivor memory
  state_t  prv_st [`STATE_NUM];
  // traceback start point
  state_t  sel_node;
  metric_t best_metric;
  // survivor read port
  step_t   rd_step;
  state_t  rd_row [`STATE_NUM];

  viterbi_control u_control (
    .clk         (clk),
    .rst_n       (rst_n),
    .sym_valid   (sym_valid),
    .sym_ready   (sym_ready),
    .acs_en      (acs_en),
    .frame_start (frame_start),
    .step        (step),
    .trace_start (trace_start),
    .trace_done  (trace_done)
  );

  add_compare_select u_acs (
    .clk         (clk),
    .rst_n       (rst_n),
    .acs_en      (acs_en),
    .frame_start (frame_start),
    .sym         (sym),
    .prv_st      (prv_st),
    .sel_node    (sel_node),
    .best_metric (best_metric)
  );

  survivor_memory u_survivor (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (acs_en),
    .wr_step (step),
    .wr_row  (prv_st),
    .rd_step (rd_step),
    .rd_row  (rd_row)
  );

  traceback u_traceback (
    .clk          (clk),
    .rst_n        (rst_n),
    .trace_start  (trace_start),
    .sel_node     (sel_node),
    .best_metric  (best_metric),
    .rd_step      (rd_step),
    .rd_row       (rd_row),
    .frame_valid  (frame_valid),
    .frame_ready  (frame_ready),
    .frame_data   (frame_data),
    .frame_metric (frame_metric),
    .trace_done   (trace_done)
  );

endmodule

/* src/viterbi_macros.svh */
`ifndef VITERBI_MACROS_SVH
`define VITERBI_MACROS_SVH

// rate 1/2 code, generators 7 and 5 (octal)
`define CONSTRAINT_LENGTH 3

// 2 ** (constraint length - 1)
`define STATE_NUM 4

// symbols in and decoded bits out per frame
`define DATA_FRAME_LENGTH 8

// 8 steps at up to 2 per step stays far below 31
`define METRIC_WIDTH 5

`endif

/* src/viterbi_pkg.sv */
`include "viterbi_macros.svh"

package viterbi_pkg;

  // received pair, bit 1 from generator 7, bit 0 from generator 5
  typedef logic [1:0] code_sym_t;

  // last two input bits, newest in bit 1
  typedef logic [`CONSTRAINT_LENGTH-2:0] state_t;

  // accumulated hamming distance
  typedef logic [`METRIC_WIDTH-1:0] metric_t;

  // trellis step within a frame
  typedef logic [$clog2(`DATA_FRAME_LENGTH)-1:0] step_t;

  // decoded bits, step 0 in bit 0
  typedef logic [`DATA_FRAME_LENGTH-1:0] frame_t;

  // frame sequencer
  typedef enum logic [1:0] {
    accept,
    drain,
    trace
  } ctrl_state_t;

endpackage

/* test/tb_viterbi_decoder.sv */
`include "viterbi_macros.svh"
`timescale 1ns/10ps

module tb_viterbi_decoder
  import viterbi_pkg::*;
();

  localparam int FRAME_TOTAL    = 42;
  localparam int TIMEOUT_CYCLES = FRAME_TOTAL * 40;
  localparam int METRIC_LARGE   = (1 << `METRIC_WIDTH) - 1;
  localparam int STALL_MAX      = 8;
  // generator taps, newest bit in bit 2
  localparam logic [2:0] GEN_A  = 3'o7;
  localparam logic [2:0] GEN_B  = 3'o5;

  logic      clk;
  logic      rst_n;
  logic      sym_valid;
  logic      sym_ready;
  code_sym_t sym;
  logic      frame_valid;
  logic      frame_ready;
  frame_t    frame_data;
  metric_t   frame_metric;

  logic [31:0] lfsr_state;
  // channel symbols of the current frame, after noise
  code_sym_t   chan_sym [`DATA_FRAME_LENGTH];
  logic [1:0]  gap_len  [`DATA_FRAME_LENGTH];
  // bit set means ready on that stalled cycle
  logic [STALL_MAX-1:0] ready_mask;
  logic        frame_sent;
  int          cycle_count;
  int          frame_errors;
  int          metric_errors;
  int          protocol_errors;
  int          frames_done;

  viterbi_decoder UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .sym_valid    (sym_valid),
    .sym_ready    (sym_ready),
    .sym          (sym),
    .frame_valid  (frame_valid),
    .frame_ready  (frame_ready),
    .frame_data   (frame_data),
    .frame_metric (frame_metric)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic tap_parity(input logic [2:0] sr, input logic [2:0] gen);
    return ^(sr & gen);
  endfunction

  // shift register encoder, starts from all zero
  task automatic encode_frame(input frame_t bits);
    logic [2:0] sr;
    sr = '0;
    for (int k = 0; k < `DATA_FRAME_LENGTH; k++) begin
      sr = {bits[k], sr[2:1]};
      chan_sym[k] = {tap_parity(sr, GEN_A), tap_parity(sr, GEN_B)};
    end
  endtask

  // a repeated position cancels, so up to flips
  task automatic add_noise(input int flips);
    logic [31:0] r;
    for (int i = 0; i < flips; i++) begin
      r = rand_bits(4);
      chan_sym[r[3:1]] = chan_sym[r[3:1]] ^ (r[0] ? 2'b10 : 2'b01);
    end
  endtask

  // full trellis search over the frame, then traceback
  task automatic reference_decode(output frame_t exp_data, output metric_t exp_metric);
    int         pm   [`STATE_NUM];
    int         cand [`STATE_NUM];
    state_t     surv [`DATA_FRAME_LENGTH][`STATE_NUM];
    state_t     from;
    state_t     to;
    state_t     node;
    logic       ub;
    logic [1:0] diff;
    int         cost;
    int         best;
    for (int s = 0; s < `STATE_NUM; s++) begin
      pm[s] = (s == 0) ? 0 : METRIC_LARGE;
    end
    for (int k = 0; k < `DATA_FRAME_LENGTH; k++) begin
      for (int n = 0; n < `STATE_NUM; n++) begin
        cand[n] = METRIC_LARGE + 1;
      end
      // ascending predecessor order, strict compare keeps the lower one
      for (int p = 0; p < `STATE_NUM; p++) begin
        for (int u = 0; u < 2; u++) begin
          from = state_t'(p);
          ub   = u[0];
          to   = {ub, from[1]};
          diff = chan_sym[k] ^ {tap_parity({ub, from}, GEN_A), tap_parity({ub, from}, GEN_B)};
          cost = pm[p] + int'(diff[1]) + int'(diff[0]);
          if (cost > METRIC_LARGE) begin
            cost = METRIC_LARGE;
          end
          if (cost < cand[to]) begin
            cand[to]    = cost;
            surv[k][to] = from;
          end
        end
      end
      pm = cand;
    end
    best = 0;
    for (int s = 1; s < `STATE_NUM; s++) begin
      if (pm[s] < pm[best]) begin
        best = s;
      end
    end
    exp_metric = metric_t'(pm[best]);
    node = state_t'(best);
    for (int k = `DATA_FRAME_LENGTH - 1; k >= 0; k--) begin
      exp_data[k] = node[1];
      node = surv[k][node];
    end
  endtask

  task automatic check_frame(input frame_t exp, input frame_t got, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
      frame_errors++;
    end
  endtask

  task automatic check_metric(input metric_t exp, input metric_t got, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, what, exp, got);
      metric_errors++;
    end
  endtask

  task automatic next_drive();
    @(posedge clk);
    #2;
  endtask

  task automatic send_frame();
    logic taken;
    for (int i = 0; i < `DATA_FRAME_LENGTH; i++) begin
      if (gap_len[i] != 2'd0) begin
        sym_valid = 1'b0;
        repeat (gap_len[i]) next_drive();
      end
      sym_valid = 1'b1;
      sym       = chan_sym[i];
      taken     = 1'b0;
      // ready seen mid cycle means taken on the next edge
      while (!taken) begin
        @(negedge clk);
        taken = sym_ready;
        next_drive();
      end
    end
    sym_valid  = 1'b0;
    frame_sent = 1'b1;
  endtask

  task automatic receive_frame(input frame_t exp_data, input metric_t exp_metric);
    int      stall_idx;
    logic    done;
    logic    held;
    frame_t  held_data;
    metric_t held_metric;
    stall_idx = 0;
    done      = 1'b0;
    held      = 1'b0;
    while (!done) begin
      frame_ready = (stall_idx < STALL_MAX) ? ready_mask[stall_idx] : 1'b1;
      @(negedge clk);
      if (frame_sent && sym_ready) begin
        $display("error at %0t: sym_ready went high before the frame handshake", $time);
        protocol_errors++;
      end
      if (frame_valid) begin
        if (held) begin
          check_frame(held_data, frame_data, "held frame_data");
          check_metric(held_metric, frame_metric, "held frame_metric");
        end
        if (frame_ready) begin
          check_frame(exp_data, frame_data, "decoded frame");
          check_metric(exp_metric, frame_metric, "frame metric");
          done = 1'b1;
        end else begin
          held        = 1'b1;
          held_data   = frame_data;
          held_metric = frame_metric;
          stall_idx++;
        end
      end
      next_drive();
    end
    frame_ready = 1'b0;
    @(negedge clk);
    if (!sym_ready) begin
      $display("error at %0t: sym_ready did not return after the frame handshake", $time);
      protocol_errors++;
    end
  endtask

  // draws data, noise and handshake timing, then runs one frame
  task automatic run_frame(input int min_flips, input int max_flips, input logic gaps,
                           input logic stalls);
    frame_t      data;
    frame_t      exp_data;
    metric_t     exp_metric;
    logic [31:0] r;
    int          flips;
    data = frame_t'(rand_bits(`DATA_FRAME_LENGTH));
    encode_frame(data);
    r = rand_bits(3);
    flips = min_flips + int'(r % (max_flips - min_flips + 1));
    add_noise(flips);
    if (flips == 0) begin
      // clean channel gives back the data at zero distance
      exp_data   = data;
      exp_metric = '0;
    end else begin
      reference_decode(exp_data, exp_metric);
    end
    for (int i = 0; i < `DATA_FRAME_LENGTH; i++) begin
      gap_len[i] = gaps ? 2'(rand_bits(2)) : 2'd0;
    end
    ready_mask = stalls ? STALL_MAX'(rand_bits(STALL_MAX)) : '1;
    frame_sent = 1'b0;
    fork
      send_frame();
      receive_frame(exp_data, exp_metric);
    join
    next_drive();
    frames_done++;
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: decoder did not finish all frames within %0d cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rst_n           = 1'b0;
    sym_valid       = 1'b0;
    sym             = '0;
    frame_ready     = 1'b0;
    frame_sent      = 1'b0;
    lfsr_state      = 32'he246_b831;
    frame_errors    = 0;
    metric_errors   = 0;
    protocol_errors = 0;
    frames_done     = 0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // error-free
    repeat (4) run_frame(0, 0, 1'b0, 1'b0);
    // single flipped bit
    repeat (6) run_frame(1, 1, 1'b0, 1'b0);
    // heavy corruption, ties likely
    repeat (6) run_frame(2, 4, 1'b0, 1'b0);
    // valid gaps and ready stalls
    repeat (6) run_frame(0, 4, 1'b1, 1'b1);
    // back to back, metrics restart each frame
    repeat (20) run_frame(0, 4, 1'b0, 1'b0);
    $display("errors: frame %0d, metric %0d, protocol %0d over %0d frames",
             frame_errors, metric_errors, protocol_errors, frames_done);
    if (frame_errors + metric_errors + protocol_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
